// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ##########################################################
    // Widths
    // ##########################################################
    localparam int data_width  = 8;   // Data, data addresses and PC
    localparam int instr_width = 16;

    // Instruction field positions
    localparam int op_msb  = 15;
    localparam int op_lsb  = 12;
    localparam int ra_msb  = 11;      // Register a, also the destination
    localparam int ra_lsb  = 10;
    localparam int rb_msb  = 9;
    localparam int rb_lsb  = 8;
    localparam int imm_msb = 7;
    localparam int imm_lsb = 0;

    // ##########################################################
    // Encodings
    // ##########################################################
    typedef enum logic [3:0] {
        op_jmp  = 4'd0,
        op_lod  = 4'd1,
        op_str  = 4'd2,
        op_add  = 4'd3,
        op_addi = 4'd4,
        op_lodi = 4'd5,
        op_nand = 4'd6,
        op_jeqz = 4'd7,
        op_halt = 4'd8
    } opcode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_write,
        st_halted
    } ctrl_state_t;

    // Opcodes whose result lands in register a
    function automatic logic writes_register(input opcode_t op);
        return op inside {op_lod, op_add, op_addi, op_lodi, op_nand};
    endfunction

endpackage

`default_nettype wire

// File: design/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,

    // Program load port
    input  logic                   load_we,
    input  logic [data_width-1:0]  load_addr,
    input  logic [instr_width-1:0] load_data,
    input  logic                   load_allow,

    // Sequencing from the controller
    input  logic                   fetch,
    input  logic                   pc_write,
    input  logic [data_width-1:0]  pc_next,
    input  logic                   pc_clear,

    output logic [instr_width-1:0] instr,
    output logic [data_width-1:0]  pc
);

    localparam int depth = 2 ** data_width;

    logic [instr_width-1:0] prog_mem [depth];
    logic                   mem_we;

    // ##########################################################
    // Program memory
    // ##########################################################

    // Writes are locked out while a program is running
    assign mem_we = load_we && load_allow;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            prog_mem[load_addr] <= load_data;
        end
    end

    // ##########################################################
    // Program counter
    // ##########################################################
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_clear) begin
            pc <= '0;                // Start always runs from address 0
        end else if (pc_write) begin
            pc <= pc_next;
        end
    end

    // Instruction register, stable from the end of fetch until the next fetch
    always_ff @(posedge clk) begin
        if (fetch) begin
            instr <= prog_mem[pc];
        end
    end

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [1:0]            sel_a,
    input  logic [1:0]            sel_b,
    input  logic                  we,
    input  logic [data_width-1:0] wdata,
    output logic [data_width-1:0] rdata_a,
    output logic [data_width-1:0] rdata_b
);

    logic [data_width-1:0] regs [4];

    // Write port shares the select of read port a
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[sel_a] <= wdata;
        end
    end

    // Combinational reads
    assign rdata_a = regs[sel_a];
    assign rdata_b = regs[sel_b];

endmodule

`default_nettype wire

// File: design/exec.sv
`timescale 1ns/10ps
`default_nettype none

module exec import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  en,
    input  opcode_t               op,
    input  logic [data_width-1:0] reg0,
    input  logic [data_width-1:0] reg1,
    input  logic [data_width-1:0] imm,
    input  logic [data_width-1:0] pc_in,
    output logic [data_width-1:0] val_out,
    output logic [data_width-1:0] pc_out,
    output logic                  take_branch,
    output logic                  ready,

    // APB master
    output logic                  psel,
    output logic                  penable,
    output logic                  pwrite,
    output logic [data_width-1:0] paddr,
    output logic [data_width-1:0] pwdata,
    input  logic [data_width-1:0] prdata,
    input  logic                  pready
);

    typedef enum logic [1:0] {
        cyc_first,      // Compute, or launch the APB setup phase
        cyc_setup,
        cyc_access,     // Waits here on pready
        cyc_done
    } cycle_t;

    cycle_t cycle;
    logic   is_mem;
    logic   branch_taken;
    logic   first;

    assign is_mem       = (op == op_lod) || (op == op_str);
    assign branch_taken = (op == op_jmp) || ((op == op_jeqz) && (reg1 == '0));
    assign first        = en && (cycle == cyc_first);

    // ##########################################################
    // Cycle control and APB handshake
    // ##########################################################
    always_ff @(posedge clk) begin
        if (reset || !en) begin
            cycle       <= cyc_first;   // Dropping en ends the instruction
            ready       <= 1'b0;
            take_branch <= 1'b0;
            psel        <= 1'b0;
            penable     <= 1'b0;
            pwrite      <= 1'b0;
        end else begin
            case (cycle)
                cyc_first: begin
                    take_branch <= branch_taken;
                    if (is_mem) begin
                        psel   <= 1'b1;
                        pwrite <= (op == op_str);
                        cycle  <= cyc_setup;
                    end else begin
                        cycle <= cyc_done;
                    end
                end
                cyc_setup: begin
                    penable <= 1'b1;
                    cycle   <= cyc_access;
                end
                cyc_access: begin
                    if (pready) begin
                        psel    <= 1'b0;
                        penable <= 1'b0;
                        ready   <= 1'b1;   // Same edge as the read capture
                        cycle   <= cyc_done;
                    end
                end
                default: ready <= 1'b1;
            endcase
        end
    end

    // ##########################################################
    // Results, branch target and APB payload
    // ##########################################################
    always_ff @(posedge clk) begin
        if (first) begin
            pc_out <= branch_taken ? imm + reg0 : pc_in + 1'b1;
            paddr  <= reg1 + imm;
            pwdata <= reg0;
            case (op)
                op_add:  val_out <= reg0 + reg1;
                op_addi: val_out <= reg0 + imm;
                op_lodi: val_out <= imm;
                op_nand: val_out <= ~(reg0 & reg1);
                default: ;
            endcase
        end
        if (en && (cycle == cyc_access) && pready && !pwrite) begin
            val_out <= prdata;       // Load data
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_control.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    start,
    input  opcode_t op,
    input  logic    exec_ready,
    input  logic    take_branch,
    output logic    fetch,
    output logic    exec_en,
    output logic    reg_we,
    output logic    pc_write,
    output logic    pc_clear,
    output logic    load_allow,
    output logic    halted
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        stopped;

    assign stopped = (state == st_idle) || (state == st_halted);

    // ##########################################################
    // Sequencer FSM
    // ##########################################################
    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_halted: if (start) state_next = st_fetch;
            st_fetch:           state_next = st_exec;
            st_exec: begin
                if (exec_ready) begin
                    state_next = (op == op_halt) ? st_halted : st_write;
                end
            end
            st_write:           state_next = st_fetch;
            default:            state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Outputs decoded from state
    assign fetch      = (state == st_fetch);
    assign exec_en    = (state == st_exec);   // Held until exec_ready is seen
    assign pc_write   = (state == st_write);
    assign pc_clear   = stopped && start;
    assign load_allow = stopped;
    assign halted     = (state == st_halted);

    // Taken branches never write back
    assign reg_we = (state == st_write) && writes_register(op) && !take_branch;

endmodule

`default_nettype wire

// File: design/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_we,
    input  logic [data_width-1:0]  load_addr,
    input  logic [instr_width-1:0] load_data,
    input  logic                   start,
    output logic                   halted,

    // APB data memory port
    output logic                   psel,
    output logic                   penable,
    output logic                   pwrite,
    output logic [data_width-1:0]  paddr,
    output logic [data_width-1:0]  pwdata,
    input  logic [data_width-1:0]  prdata,
    input  logic                   pready
);

    logic [instr_width-1:0] instr;
    logic [data_width-1:0]  pc;
    logic [data_width-1:0]  pc_next;
    logic [data_width-1:0]  reg0;
    logic [data_width-1:0]  reg1;
    logic [data_width-1:0]  val_out;
    opcode_t                op;
    logic                   fetch;
    logic                   exec_en;
    logic                   exec_ready;
    logic                   take_branch;
    logic                   reg_we;
    logic                   pc_write;
    logic                   pc_clear;
    logic                   load_allow;

    assign op = opcode_t'(instr[op_msb:op_lsb]);

    instr_fetch instr_fetch_inst (
        .clk        (clk),
        .reset      (reset),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .load_allow (load_allow),
        .fetch      (fetch),
        .pc_write   (pc_write),
        .pc_next    (pc_next),
        .pc_clear   (pc_clear),
        .instr      (instr),
        .pc         (pc)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .reset   (reset),
        .sel_a   (instr[ra_msb:ra_lsb]),
        .sel_b   (instr[rb_msb:rb_lsb]),
        .we      (reg_we),
        .wdata   (val_out),
        .rdata_a (reg0),
        .rdata_b (reg1)
    );

    exec exec_inst (
        .clk         (clk),
        .reset       (reset),
        .en          (exec_en),
        .op          (op),
        .reg0        (reg0),
        .reg1        (reg1),
        .imm         (instr[imm_msb:imm_lsb]),
        .pc_in       (pc),
        .val_out     (val_out),
        .pc_out      (pc_next),
        .take_branch (take_branch),
        .ready       (exec_ready),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready)
    );

    cpu_control cpu_control_inst (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .op          (op),
        .exec_ready  (exec_ready),
        .take_branch (take_branch),
        .fetch       (fetch),
        .exec_en     (exec_en),
        .reg_we      (reg_we),
        .pc_write    (pc_write),
        .pc_clear    (pc_clear),
        .load_allow  (load_allow),
        .halted      (halted)
    );

endmodule

`default_nettype wire

// File: verification/cpu_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_asserts import cpu_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  en,
    input logic                  ready,
    input logic                  psel,
    input logic                  penable,
    input logic                  pwrite,
    input logic [data_width-1:0] paddr,
    input logic [data_width-1:0] pwdata,
    input logic                  pready
);

    int fail_count = 0;   // Read by the testbench at the end of the run

    // ##########################################################
    // APB master protocol
    // ##########################################################
    penable_with_psel: assert property (@(posedge clk) disable iff (reset)
        penable |-> psel)
    else begin
        fail_count++;
        $error("penable high while psel is low");
    end

    setup_then_access: assert property (@(posedge clk) disable iff (reset)
        $rose(psel) |=> penable)
    else begin
        fail_count++;
        $error("Setup phase not followed by the access phase");
    end

    // Payload held while the slave stalls
    payload_stable: assert property (@(posedge clk) disable iff (reset)
        (psel && !pready) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
    else begin
        fail_count++;
        $error("APB payload changed during a stalled transfer");
    end

    // ##########################################################
    // Execute stage handshake
    // ##########################################################
    ready_clears: assert property (@(posedge clk) disable iff (reset)
        $fell(en) |=> !ready)
    else begin
        fail_count++;
        $error("ready still high one cycle after en fell");
    end

endmodule

bind exec cpu_asserts cpu_asserts_inst (
    .clk     (clk),
    .reset   (reset),
    .en      (en),
    .ready   (ready),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pready  (pready)
);

`default_nettype wire

// File: verification/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int row_count   = 12;
    localparam int cycle_limit = 60 * row_count + 500;

    typedef struct {
        opcode_t    op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] imm;
        logic [7:0] expected;
    } row_t;

    logic        clk;
    logic        reset;
    logic        load_we;
    logic [7:0]  load_addr;
    logic [15:0] load_data;
    logic        start;
    logic        halted;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;

    row_t        rows [row_count];
    logic [15:0] prog [$];
    logic [7:0]  mem [256];
    logic [7:0]  wr_addr [$];   // Every completed APB write
    logic [7:0]  wr_data [$];
    int          wait_cnt;
    int          cycles = 0;
    int          errors = 0;

    cpu_top cpu_top_inst (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // ##########################################################
    // APB memory model with 0 to 3 random wait cycles
    // ##########################################################
    always @(negedge clk) begin
        pready = 1'b0;
        if (psel && !penable) begin
            wait_cnt = int'($urandom % 4);   // Picked in the setup phase
        end else if (psel && penable) begin
            if (wait_cnt == 0) begin
                pready = 1'b1;
                if (pwrite) begin
                    mem[paddr] = pwdata;
                    wr_addr.push_back(paddr);
                    wr_data.push_back(pwdata);
                end else begin
                    prdata = mem[paddr];
                end
            end else begin
                wait_cnt--;
            end
        end
    end

    function automatic logic [15:0] encode(opcode_t op, logic [1:0] ra, logic [1:0] rb,
                                           logic [7:0] imm);
        logic [15:0] word;
        word                  = '0;
        word[op_msb:op_lsb]   = op;
        word[ra_msb:ra_lsb]   = ra;
        word[rb_msb:rb_lsb]   = rb;
        word[imm_msb:imm_lsb] = imm;
        return word;
    endfunction

    function automatic logic [7:0] preset_byte(logic [7:0] addr);
        return addr ^ 8'h5a;
    endfunction

    // Value left in r0 by the row's instruction, with r0 = a and r1 = b
    function automatic row_t make_row(opcode_t op, logic [7:0] a, logic [7:0] b,
                                      logic [7:0] imm);
        row_t r;
        r = '{op, a, b, imm, 8'h00};
        case (op)
            op_add:  r.expected = a + b;
            op_addi: r.expected = a + imm;
            op_lodi: r.expected = imm;
            op_nand: r.expected = ~(a & b);
            op_lod:  r.expected = preset_byte(b + imm);
            default: r.expected = a;
        endcase
        return r;
    endfunction

    task automatic check(string name, logic [15:0] actual, logic [15:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic load_program();
        foreach (prog[i]) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = 8'(i);
            load_data = prog[i];
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    task automatic run_program(logic was_halted);
        check("halted", halted, was_halted);   // Halt holds through the reload
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check("halted", halted, 1'b0);
        while (!halted) begin
            @(negedge clk);
        end
        check("psel", psel, 1'b0);
    endtask

    // Exactly one store per program
    task automatic check_store(logic [7:0] addr, logic [7:0] data);
        check("write_count", 16'(wr_addr.size()), 16'd1);
        if (wr_addr.size() > 0) begin
            check("paddr", wr_addr[0], addr);
            check("pwdata", wr_data[0], data);
        end
        wr_addr.delete();
        wr_data.delete();
    endtask

    initial begin
        void'($urandom(32'h15cc_42ce));
        clk       = 1'b0;
        reset     = 1'b1;
        load_we   = 1'b0;
        load_addr = 8'h00;
        load_data = 16'h0000;
        start     = 1'b0;
        prdata    = 8'h00;
        pready    = 1'b0;
        foreach (mem[i]) begin
            mem[i] = preset_byte(8'(i));
        end

        rows[0]  = make_row(op_add,  8'h12, 8'h34, 8'h00);
        rows[1]  = make_row(op_add,  8'hff, 8'h02, 8'h00);   // Overflow
        rows[2]  = make_row(op_addi, 8'h80, 8'h00, 8'h85);
        rows[3]  = make_row(op_addi, 8'h10, 8'h99, 8'h01);
        rows[4]  = make_row(op_lodi, 8'h33, 8'h44, 8'ha5);
        rows[5]  = make_row(op_lodi, 8'hff, 8'hff, 8'h00);
        rows[6]  = make_row(op_nand, 8'hf0, 8'h3c, 8'h00);
        rows[7]  = make_row(op_nand, 8'hff, 8'hff, 8'h00);
        rows[8]  = make_row(op_lod,  8'h00, 8'h10, 8'h05);
        rows[9]  = make_row(op_lod,  8'h00, 8'h7f, 8'h85);   // Address wraps to 8'h04
        rows[10] = make_row(op_lod,  8'h00, 8'h00, 8'h00);
        rows[11] = make_row(op_lod,  8'h77, 8'h30, 8'h0c);

        repeat (2) @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < row_count; i++) begin
            prog.delete();
            prog.push_back(encode(op_lodi, 2'd0, 2'd0, rows[i].a));
            prog.push_back(encode(op_lodi, 2'd1, 2'd0, rows[i].b));
            prog.push_back(encode(rows[i].op, 2'd0, 2'd1, rows[i].imm));
            prog.push_back(encode(op_lodi, 2'd3, 2'd0, 8'h80 + 8'(i)));
            prog.push_back(encode(op_str, 2'd0, 2'd3, 8'h00));
            prog.push_back(encode(op_halt, 2'd0, 2'd0, 8'h00));
            load_program();
            run_program(i > 0);
            check_store(8'h80 + 8'(i), rows[i].expected);
        end

        // Branch program, r0 ends at 8'h31 only if every branch goes the right way
        prog.delete();
        prog.push_back(encode(op_lodi, 2'd2, 2'd0, 8'h00));
        prog.push_back(encode(op_lodi, 2'd0, 2'd0, 8'h01));
        prog.push_back(encode(op_lodi, 2'd1, 2'd0, 8'h00));
        prog.push_back(encode(op_jeqz, 2'd2, 2'd1, 8'h05));   // Taken, to 5
        prog.push_back(encode(op_lodi, 2'd0, 2'd0, 8'hee));
        prog.push_back(encode(op_addi, 2'd0, 2'd0, 8'h10));   // r0 = 8'h11
        prog.push_back(encode(op_lodi, 2'd1, 2'd0, 8'h07));
        prog.push_back(encode(op_jeqz, 2'd2, 2'd1, 8'h09));   // Not taken
        prog.push_back(encode(op_addi, 2'd0, 2'd0, 8'h20));   // r0 = 8'h31
        prog.push_back(encode(op_lodi, 2'd2, 2'd0, 8'h03));
        prog.push_back(encode(op_jmp,  2'd2, 2'd0, 8'h09));   // To 9 + r2 = 12
        prog.push_back(encode(op_lodi, 2'd0, 2'd0, 8'hdd));
        prog.push_back(encode(op_lodi, 2'd3, 2'd0, 8'h90));
        prog.push_back(encode(op_str,  2'd0, 2'd3, 8'h00));
        prog.push_back(encode(op_halt, 2'd0, 2'd0, 8'h00));
        load_program();
        run_program(1'b1);
        check_store(8'h90, 8'h31);

        errors += cpu_top_inst.exec_inst.cpu_asserts_inst.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/cpu_pkg.sv
design/instr_fetch.sv
design/reg_file.sv
design/exec.sv
design/cpu_control.sv
design/cpu_top.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f verilog.f -o cpu_sim

status=0
./obj_dir/cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "RESULT: FAIL" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
